// ==== verilog/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	//////////////////////////////
	// Word widths
	localparam int DATA_W = 8;
	localparam int WGT_W  = 8;

	//////////////////////////////
	// Default layer geometry
	localparam int DEF_IMG_W = 4;
	localparam int DEF_C_IN  = 4;
	localparam int DEF_C_OUT = 8;
	localparam int DEF_LANES = 4;
	localparam int DEF_GAP   = 3;

	// One extra bit for the sign of an unsigned x signed product
	localparam int ACC_W = DATA_W + WGT_W + $clog2(DEF_C_IN) + 1;

	// Index width that never drops to zero bits
	function automatic int idx_w(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/fmap_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module fmap_ram #(
	parameter int IMG_W = conv_pkg::DEF_IMG_W,
	parameter int C_IN  = conv_pkg::DEF_C_IN
) (
	input  wire                                            clk,
	input  wire                                            en,
	input  wire                                            we,
	input  wire  [conv_pkg::idx_w(C_IN*IMG_W*IMG_W)-1:0]   addr,
	input  wire  [conv_pkg::DATA_W-1:0]                    din,
	output logic [conv_pkg::DATA_W-1:0]                    dout
);
	import conv_pkg::*;

	localparam int DEPTH = C_IN * IMG_W * IMG_W;

	logic [DATA_W-1:0] mem [DEPTH];

	// Write-first, the written word comes straight back on dout
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
				dout      <= din;
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/weight_rom.sv ====
`default_nettype none
`timescale 1ns/1ps

module weight_rom #(
	parameter int C_IN    = conv_pkg::DEF_C_IN,
	parameter int C_OUT   = conv_pkg::DEF_C_OUT,
	parameter int LANES   = conv_pkg::DEF_LANES,
	parameter int LANE_ID = 0
) (
	input  wire                                        clk,
	input  wire  [conv_pkg::idx_w(C_OUT/LANES)-1:0]    pass,
	input  wire  [conv_pkg::idx_w(C_IN)-1:0]           chan,
	output logic signed [conv_pkg::WGT_W-1:0]          weight
);
	import conv_pkg::*;

	localparam int PASSES = C_OUT / LANES;
	localparam int ROM_AW = idx_w(PASSES * C_IN);

	logic        [WGT_W-1:0]  wtab [C_OUT * C_IN];
	logic signed [WGT_W-1:0]  rom  [PASSES * C_IN];
	logic        [ROM_AW-1:0] rd_addr;

	// Keep only the output channels this lane computes
	initial begin
		$readmemh("weights.hex", wtab);
		for (int p = 0; p < PASSES; p++)
			for (int c = 0; c < C_IN; c++)
				rom[p * C_IN + c] = wtab[(p * LANES + LANE_ID) * C_IN + c];
	end

	assign rd_addr = ROM_AW'(pass * C_IN + chan);

	always_ff @(posedge clk) begin
		weight <= rom[rd_addr];
	end

endmodule

`default_nettype wire

// ==== verilog/fmap_replay_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module fmap_replay_buffer #(
	parameter int IMG_W = conv_pkg::DEF_IMG_W,
	parameter int C_IN  = conv_pkg::DEF_C_IN,
	parameter int C_OUT = conv_pkg::DEF_C_OUT,
	parameter int LANES = conv_pkg::DEF_LANES,
	parameter int GAP   = conv_pkg::DEF_GAP
) (
	input  wire                                         clk,
	input  wire                                         reset,
	input  wire                                         pixel_valid,
	input  wire  [conv_pkg::DATA_W-1:0]                 pixel_data,
	output logic                                        busy,
	output logic                                        fm_valid,
	output logic [conv_pkg::DATA_W-1:0]                 fm_data,
	output logic [conv_pkg::idx_w(C_IN)-1:0]            fm_chan,
	output logic [conv_pkg::idx_w(C_OUT/LANES)-1:0]     fm_pass
);
	import conv_pkg::*;

	localparam int WORDS    = C_IN * IMG_W * IMG_W;
	localparam int PASSES   = C_OUT / LANES;
	localparam int ADDR_W   = idx_w(WORDS);
	localparam int CHAN_W   = idx_w(C_IN);
	localparam int PASS_W   = idx_w(PASSES);
	localparam int DRAIN    = LANES + 3;
	localparam int WAIT_MAX = (GAP > DRAIN) ? GAP : DRAIN;
	localparam int WAIT_W   = idx_w(WAIT_MAX);

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_WRITE = 3'd1;
	localparam logic [2:0] ST_GAP   = 3'd2;
	localparam logic [2:0] ST_READ  = 3'd3;
	localparam logic [2:0] ST_DRAIN = 3'd4;

	logic              in_valid_q;
	logic [DATA_W-1:0] in_data_q;
	logic [2:0]        state;
	logic [ADDR_W-1:0] addr;
	logic [CHAN_W-1:0] chan;
	logic [PASS_W-1:0] pass;
	logic [WAIT_W-1:0] wait_cnt;
	logic              ram_en;
	logic              ram_we;
	logic              last_word;

	//////////////////////////////
	// Input register
	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= pixel_valid && (state == ST_IDLE || state == ST_WRITE);
		end
		in_data_q <= pixel_data;
	end

	assign ram_we    = (state == ST_WRITE) && in_valid_q;
	assign ram_en    = ram_we || (state == ST_READ);
	assign last_word = (addr == ADDR_W'(WORDS - 1));
	assign busy      = (state != ST_IDLE);

	//////////////////////////////
	// Pass sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_IDLE;
			addr     <= '0;
			chan     <= '0;
			pass     <= '0;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (pixel_valid) begin
						state <= ST_WRITE;
						addr  <= '0;
						chan  <= '0;
						pass  <= '0;
					end
				end
				ST_WRITE, ST_READ: begin
					if (ram_en) begin
						if (last_word) begin
							addr     <= '0;
							chan     <= '0;
							wait_cnt <= '0;
							if (pass == PASS_W'(PASSES - 1)) begin
								state <= ST_DRAIN;
							end else begin
								state <= ST_GAP;
								pass  <= pass + 1'b1;
							end
						end else begin
							addr <= addr + 1'b1;
							chan <= (chan == CHAN_W'(C_IN - 1)) ? '0 : chan + 1'b1;
						end
					end
				end
				ST_GAP: begin
					if (wait_cnt == WAIT_W'(GAP - 1)) state <= ST_READ;
					else wait_cnt <= wait_cnt + 1'b1;
				end
				// Hold busy until the last burst has left the serializer
				ST_DRAIN: begin
					if (wait_cnt == WAIT_W'(DRAIN - 1)) state <= ST_IDLE;
					else wait_cnt <= wait_cnt + 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	fmap_ram #(
		.IMG_W (IMG_W),
		.C_IN  (C_IN)
	) u_ram (
		.clk  (clk),
		.en   (ram_en),
		.we   (ram_we),
		.addr (addr),
		.din  (in_data_q),
		.dout (fm_data)
	);

	// Indices line up with the registered RAM output
	always_ff @(posedge clk) begin
		if (reset) fm_valid <= 1'b0;
		else fm_valid <= ram_en;
		fm_chan <= chan;
		fm_pass <= pass;
	end

endmodule

`default_nettype wire

// ==== verilog/pointwise_lane.sv ====
`default_nettype none
`timescale 1ns/1ps

module pointwise_lane #(
	parameter int C_IN    = conv_pkg::DEF_C_IN,
	parameter int C_OUT   = conv_pkg::DEF_C_OUT,
	parameter int LANES   = conv_pkg::DEF_LANES,
	parameter int LANE_ID = 0
) (
	input  wire                                        clk,
	input  wire                                        reset,
	input  wire                                        fm_valid,
	input  wire  [conv_pkg::DATA_W-1:0]                fm_data,
	input  wire  [conv_pkg::idx_w(C_IN)-1:0]           fm_chan,
	input  wire  [conv_pkg::idx_w(C_OUT/LANES)-1:0]    fm_pass,
	output logic                                       lane_valid,
	output logic signed [conv_pkg::ACC_W-1:0]          lane_result
);
	import conv_pkg::*;

	logic                              valid_d;
	logic        [idx_w(C_IN)-1:0]     chan_d;
	logic        [DATA_W-1:0]          px_d;
	logic signed [WGT_W-1:0]           weight;
	logic signed [DATA_W+WGT_W:0]      prod;
	logic signed [ACC_W-1:0]           acc_base;
	logic signed [ACC_W-1:0]           acc;

	weight_rom #(
		.C_IN    (C_IN),
		.C_OUT   (C_OUT),
		.LANES   (LANES),
		.LANE_ID (LANE_ID)
	) u_rom (
		.clk    (clk),
		.pass   (fm_pass),
		.chan   (fm_chan),
		.weight (weight)
	);

	// Pixel waits one cycle for its weight
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_d    <= 1'b0;
			lane_valid <= 1'b0;
		end else begin
			valid_d    <= fm_valid;
			lane_valid <= valid_d && (chan_d == idx_w(C_IN)'(C_IN - 1));
		end
		chan_d <= fm_chan;
		px_d   <= fm_data;
	end

	assign prod = $signed({1'b0, px_d}) * weight;

	// Restart on channel 0
	always_comb begin
		if (chan_d == '0) acc_base = '0;
		else acc_base = acc;
	end

	always_ff @(posedge clk) begin
		if (valid_d) acc <= acc_base + prod;
	end

	// Full sum stays in acc for the cycle after the last channel
	assign lane_result = acc;

endmodule

`default_nettype wire

// ==== verilog/ofmap_serializer.sv ====
`default_nettype none
`timescale 1ns/1ps

module ofmap_serializer #(
	parameter int LANES = conv_pkg::DEF_LANES
) (
	input  wire                                          clk,
	input  wire                                          reset,
	input  wire  [LANES-1:0]                             lane_valid,
	input  wire  [LANES-1:0][conv_pkg::ACC_W-1:0]        lane_result,
	output logic                                         out_valid,
	output logic signed [conv_pkg::ACC_W-1:0]            out_data
);
	import conv_pkg::*;

	localparam int CNT_W = idx_w(LANES + 1);

	logic                         load;
	logic [LANES-1:0][ACC_W-1:0]  hold;
	logic [CNT_W-1:0]             cnt;

	// Every lane strobes together
	assign load = |lane_valid;

	//////////////////////////////
	// Holding register
	// Lane 0 sits in the low word and leaves first
	always_ff @(posedge clk) begin
		if (load) begin
			hold <= lane_result;
		end else if (cnt != '0) begin
			hold <= hold >> ACC_W;
		end
	end

	//////////////////////////////
	// Burst length
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= CNT_W'(LANES);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign out_valid = (cnt != '0);
	assign out_data  = hold[0];

endmodule

`default_nettype wire

// ==== verilog/pointwise_conv_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module pointwise_conv_top #(
	parameter int IMG_W = conv_pkg::DEF_IMG_W,
	parameter int C_IN  = conv_pkg::DEF_C_IN,
	parameter int C_OUT = conv_pkg::DEF_C_OUT,
	parameter int LANES = conv_pkg::DEF_LANES,
	parameter int GAP   = conv_pkg::DEF_GAP
) (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 pixel_valid,
	input  wire  [conv_pkg::DATA_W-1:0]         pixel_data,
	output logic                                busy,
	output logic                                out_valid,
	output logic signed [conv_pkg::ACC_W-1:0]   out_data
);
	import conv_pkg::*;

	logic                               fm_valid;
	logic [DATA_W-1:0]                  fm_data;
	logic [idx_w(C_IN)-1:0]             fm_chan;
	logic [idx_w(C_OUT/LANES)-1:0]      fm_pass;
	logic [LANES-1:0]                   lane_valid;
	logic [LANES-1:0][ACC_W-1:0]        lane_result;

	fmap_replay_buffer #(
		.IMG_W (IMG_W),
		.C_IN  (C_IN),
		.C_OUT (C_OUT),
		.LANES (LANES),
		.GAP   (GAP)
	) u_buffer (
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.busy        (busy),
		.fm_valid    (fm_valid),
		.fm_data     (fm_data),
		.fm_chan     (fm_chan),
		.fm_pass     (fm_pass)
	);

	//////////////////////////////
	// Lane array
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		pointwise_lane #(
			.C_IN    (C_IN),
			.C_OUT   (C_OUT),
			.LANES   (LANES),
			.LANE_ID (i)
		) u_lane (
			.clk         (clk),
			.reset       (reset),
			.fm_valid    (fm_valid),
			.fm_data     (fm_data),
			.fm_chan     (fm_chan),
			.fm_pass     (fm_pass),
			.lane_valid  (lane_valid[i]),
			.lane_result (lane_result[i])
		);
	end

	ofmap_serializer #(
		.LANES (LANES)
	) u_serializer (
		.clk         (clk),
		.reset       (reset),
		.lane_valid  (lane_valid),
		.lane_result (lane_result),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

`default_nettype wire

// ==== testbench/conv_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_chk #(
	parameter int C_IN  = conv_pkg::DEF_C_IN,
	parameter int LANES = conv_pkg::DEF_LANES
) (
	input wire                                clk,
	input wire                                reset,
	input wire                                pixel_valid,
	input wire                                busy,
	input wire                                fm_valid,
	input wire [conv_pkg::idx_w(C_IN)-1:0]    fm_chan,
	input wire                                out_valid
);
	int                              fail_count = 0;
	int                              run_len;
	logic                            prev_fm_valid;
	logic                            prev_busy;
	logic                            accepted;
	logic [conv_pkg::idx_w(C_IN)-1:0] prev_chan;

	always @(posedge clk) begin
		if (reset) begin
			run_len       <= 0;
			prev_fm_valid <= 1'b0;
			prev_busy     <= 1'b0;
			accepted      <= 1'b0;
		end else begin
			run_len       <= out_valid ? run_len + 1 : 0;
			prev_fm_valid <= fm_valid;
			prev_busy     <= busy;
			if (pixel_valid && !busy) accepted <= 1'b1;
		end
		prev_chan <= fm_chan;
	end

	//////////////////////////////
	// Properties
	// Bursts may run back to back, so a run is a whole number of LANES
	a_burst_len: assert property (@(posedge clk) disable iff (reset)
		(!out_valid && run_len != 0) |-> (run_len % LANES == 0))
		else begin
			fail_count++;
			$error("out_valid run of %0d cycles", run_len);
		end

	a_chan_step: assert property (@(posedge clk) disable iff (reset)
		(fm_valid && prev_fm_valid) |-> (int'(fm_chan) == (int'(prev_chan) + 1) % C_IN))
		else begin
			fail_count++;
			$error("fm_chan skipped a channel");
		end

	a_no_frame: assert property (@(posedge clk) disable iff (reset)
		!accepted |-> !out_valid)
		else begin
			fail_count++;
			$error("out_valid before any frame");
		end

	a_busy_pass: assert property (@(posedge clk) disable iff (reset)
		fm_valid |-> busy)
		else begin
			fail_count++;
			$error("busy low during a pass");
		end

	a_busy_fall: assert property (@(posedge clk) disable iff (reset)
		(prev_busy && !busy) |-> !out_valid)
		else begin
			fail_count++;
			$error("busy fell while results were leaving");
		end

endmodule

bind pointwise_conv_top conv_chk #(
	.C_IN  (C_IN),
	.LANES (LANES)
) u_chk (
	.clk         (clk),
	.reset       (reset),
	.pixel_valid (pixel_valid),
	.busy        (busy),
	.fm_valid    (fm_valid),
	.fm_chan     (fm_chan),
	.out_valid   (out_valid)
);

`default_nettype wire

// ==== testbench/conv_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_tb;
	import conv_pkg::*;

	localparam int IMG_W   = DEF_IMG_W;
	localparam int C_IN    = DEF_C_IN;
	localparam int C_OUT   = DEF_C_OUT;
	localparam int LANES   = DEF_LANES;
	localparam int GAP     = DEF_GAP;
	localparam int WORDS   = C_IN * IMG_W * IMG_W;
	localparam int PASSES  = C_OUT / LANES;
	localparam int OUTPUTS = C_OUT * IMG_W * IMG_W;
	localparam int N_TESTS = 6;
	localparam int CYCLE_LIMIT = 2 * N_TESTS * (WORDS * (PASSES + 1) + PASSES * GAP + 20);

	// Pixel patterns and special actions
	localparam int PAT_RAMP   = 0;
	localparam int PAT_MAX    = 1;
	localparam int PAT_RANDOM = 2;
	localparam int PAT_ZERO   = 3;
	localparam int ACT_NONE   = 0;
	localparam int ACT_JUNK   = 1;
	localparam int ACT_RESET  = 2;

	logic                     clk;
	logic                     reset;
	logic                     pixel_valid;
	logic [DATA_W-1:0]        pixel_data;
	logic                     busy;
	logic                     out_valid;
	logic signed [ACC_W-1:0]  out_data;

	logic [WGT_W-1:0]         weight_mem [C_OUT * C_IN];
	logic [DATA_W-1:0]        frame [WORDS];
	logic signed [ACC_W-1:0]  exp_q [$];
	logic signed [ACC_W-1:0]  expected;
	string                    cur_name;
	integer                   seed = 10;
	int                       mismatch_count = 0;
	int                       other_count = 0;
	int                       out_count = 0;
	int                       cycles = 0;

	//////////////////////////////
	// Test table
	string test_name [N_TESTS] = '{"ramp", "all_max", "random", "zero_after_data",
		"junk_while_busy", "reset_in_replay"};
	int test_pattern [N_TESTS] = '{PAT_RAMP, PAT_MAX, PAT_RANDOM, PAT_ZERO,
		PAT_RANDOM, PAT_RAMP};
	int test_action [N_TESTS] = '{ACT_NONE, ACT_NONE, ACT_NONE, ACT_NONE,
		ACT_JUNK, ACT_RESET};

	pointwise_conv_top #(
		.IMG_W (IMG_W),
		.C_IN  (C_IN),
		.C_OUT (C_OUT),
		.LANES (LANES),
		.GAP   (GAP)
	) DUT (
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.busy        (busy),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	task automatic fill_frame(input int pattern);
		for (int i = 0; i < WORDS; i++) begin
			case (pattern)
				PAT_RAMP:   frame[i] = DATA_W'(i * 3 + 1);
				PAT_MAX:    frame[i] = '1;
				PAT_RANDOM: frame[i] = DATA_W'($random(seed));
				default:    frame[i] = '0;
			endcase
		end
	endtask

	// Reference model in pass, pixel, lane order
	task automatic load_expected();
		int o;
		int sum;
		int w;
		exp_q.delete();
		out_count = 0;
		for (int k = 0; k < PASSES; k++)
			for (int p = 0; p < IMG_W * IMG_W; p++)
				for (int l = 0; l < LANES; l++) begin
					o = k * LANES + l;
					sum = 0;
					for (int c = 0; c < C_IN; c++) begin
						w = $signed(weight_mem[o * C_IN + c]);
						sum += w * int'(frame[p * C_IN + c]);
					end
					exp_q.push_back(ACC_W'(sum));
				end
	endtask

	task automatic send_frame();
		while (busy) @(negedge clk);
		for (int i = 0; i < WORDS; i++) begin
			pixel_valid = 1'b1;
			pixel_data  = frame[i];
			@(negedge clk);
		end
		pixel_valid = 1'b0;
	endtask

	// Words offered while busy must be dropped by the buffer
	task automatic drive_junk(input int n);
		for (int i = 0; i < n; i++) begin
			pixel_valid = busy;
			pixel_data  = DATA_W'($random(seed));
			@(negedge clk);
		end
		pixel_valid = 1'b0;
	endtask

	task automatic reset_mid_frame();
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		assert (!busy && !out_valid) else begin
			other_count++;
			$display("test %s: busy or out_valid still high after reset", cur_name);
		end
		exp_q.delete();
		out_count = 0;
	endtask

	task automatic finish_frame();
		while (busy) @(negedge clk);
		repeat (4) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			other_count++;
			$display("test %s: %0d expected outputs never arrived", cur_name, exp_q.size());
		end
		assert (out_count == OUTPUTS) else begin
			mismatch_count++;
			$display("mismatch in %s output count before busy fell: expected %0d, actual %0d",
				cur_name, OUTPUTS, out_count);
		end
	endtask

	task automatic run_frame(input int pattern, input int action);
		fill_frame(pattern);
		load_expected();
		send_frame();
		if (action == ACT_JUNK) begin
			repeat (3) @(negedge clk);
			drive_junk(WORDS);
		end else if (action == ACT_RESET) begin
			// Lands inside the second pass
			repeat (GAP + WORDS / 2) @(negedge clk);
			reset_mid_frame();
			fill_frame(PAT_RANDOM);
			load_expected();
			send_frame();
		end
		finish_frame();
	endtask

	//////////////////////////////
	// Output monitor
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			// Outputs after busy falls do not count toward the frame
			if (busy) begin
				out_count++;
			end
			assert (exp_q.size() > 0) else begin
				other_count++;
				$display("test %s: extra output %0d with none expected", cur_name, out_data);
			end
			if (exp_q.size() > 0) begin
				expected = exp_q.pop_front();
				assert (out_data == expected) else begin
					mismatch_count++;
					$display("mismatch in %s: expected %0d, actual %0d",
						cur_name, expected, out_data);
				end
			end
		end
	end

	initial begin
		@(posedge clk);
		while (cycles < CYCLE_LIMIT) @(posedge clk);
		$display("Timeout: run still going after %0d cycles", cycles);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		pixel_valid = 1'b0;
		pixel_data  = '0;
		$readmemh("weights.hex", weight_mem);
		repeat (4) @(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < N_TESTS; t++) begin
			cur_name = test_name[t];
			run_frame(test_pattern[t], test_action[t]);
		end
		other_count += DUT.u_chk.fail_count;
		$display("Summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count + other_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== weights.hex ====
// Signed 8-bit weights, one per line
// Row order: output channel o, then input channel c (index o*C_IN + c)
7f
7f
7f
7f
80
80
80
80
01
02
03
04
ff
fe
fd
fc
10
f0
08
f8
05
00
fb
00
3c
c4
21
df
7f
80
01
ff

// ==== list.f ====
verilog/conv_pkg.sv
verilog/fmap_ram.sv
verilog/weight_rom.sv
verilog/fmap_replay_buffer.sv
verilog/pointwise_lane.sv
verilog/ofmap_serializer.sv
verilog/pointwise_conv_top.sv
testbench/conv_chk.sv
testbench/conv_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := conv_tb
FILE_LIST := list.f
FLAGS     := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILE_LIST))
PASS_MSG  := Done: no errors

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM) weights.hex
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
